//--- source/spi_consts.svh
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// ------------------------------
// SPI master sizing
// ------------------------------

// Bits shifted per transfer
`define SPI_DATA_WIDTH 8

// Chip selects on the bus
// Three slaves leave index 3 unused, which the decoder rejects
`define SPI_NUM_SLAVES 3

// Width of the slave index from the host
`define SPI_SEL_WIDTH 2

// Half-period divider width
`define SPI_DIV_WIDTH 16

`endif

//--- source/spi_master_pkg.sv
`include "spi_consts.svh"

package spi_master_pkg;

    // ------------------------------
    // Vector types
    // ------------------------------
    typedef logic [`SPI_DATA_WIDTH-1:0] spi_data_t;
    typedef logic [`SPI_SEL_WIDTH-1:0]  spi_sel_t;
    typedef logic [`SPI_DIV_WIDTH-1:0]  spi_div_t;
    typedef logic [`SPI_NUM_SLAVES-1:0] spi_cs_t;

    // Transfer engine states
    typedef enum logic [1:0] {
        IDLE,
        START,
        TRANSFER,
        STOP
    } spi_state_t;

    // ------------------------------
    // Bundles between blocks
    // ------------------------------

    // Command as seen on the host pins
    typedef struct packed {
        spi_data_t tx_data;
        spi_sel_t  slave_sel;
        logic      cpol;
        logic      cpha;
        spi_div_t  clk_div;
    } spi_cmd_t;

    // Decoded form that the shift engine works from
    typedef struct packed {
        spi_data_t tx_data;
        spi_cs_t   cs_mask;
        logic      cpol;
        logic      sample_on_rise;
        spi_div_t  clk_div;
    } spi_ctrl_t;

    // Received word plus end-of-transfer pulse
    typedef struct packed {
        spi_data_t rx_data;
        logic      done;
    } spi_result_t;

endpackage

//--- source/spi_cmd_decode.sv
`timescale 1ns/10ps
`include "spi_consts.svh"

module spi_cmd_decode
    import spi_master_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  spi_cmd_t  cmd,
    input  logic      engine_busy,
    output logic      launch,
    output logic      cmd_error,
    output logic      busy,
    output spi_ctrl_t ctrl
);

    logic      accept;
    logic      sel_valid;
    spi_ctrl_t ctrl_next;

    // ------------------------------
    // Command check and mode reduction
    // ------------------------------

    // Start only counts when nothing is in flight
    assign accept    = start && !busy;
    assign sel_valid = (cmd.slave_sel < `SPI_NUM_SLAVES);

    always_comb begin
        ctrl_next.tx_data = cmd.tx_data;
        ctrl_next.cs_mask = spi_cs_t'(1) << cmd.slave_sel;
        ctrl_next.cpol    = cmd.cpol;
        // Modes 0 and 3 sample on the rising edge, 1 and 2 on the falling one
        ctrl_next.sample_on_rise = (cmd.cpol == cmd.cpha);
        ctrl_next.clk_div = cmd.clk_div;
    end

    // ------------------------------
    // Latch and pulse generation
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            launch    <= 1'b0;
            cmd_error <= 1'b0;
            ctrl      <= '0;
        end else begin
            launch    <= 1'b0;
            cmd_error <= 1'b0;
            if (accept) begin
                if (sel_valid) begin
                    launch <= 1'b1;
                    ctrl   <= ctrl_next;
                end else begin
                    // Bad index, keep the old control so sclk stays put
                    cmd_error <= 1'b1;
                end
            end
        end
    end

    // Launch covers the one cycle before the engine leaves IDLE
    assign busy = launch | engine_busy;

    // ------------------------------
    // Checks
    // ------------------------------
    a_launch_xor_error : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(launch && cmd_error)
    ) else $error("launch and cmd_error high together");

    // A start during a transfer must not produce a new command
    a_start_while_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        (start && busy) |=> (!launch && !cmd_error)
    ) else $error("start accepted while busy");

endmodule

//--- source/spi_shift_engine.sv
`timescale 1ns/10ps
`include "spi_consts.svh"

module spi_shift_engine
    import spi_master_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        launch,
    input  spi_ctrl_t   ctrl,
    input  logic        miso,
    output logic        sclk,
    output logic        mosi,
    output spi_cs_t     cs_n,
    output logic        engine_busy,
    output spi_result_t res
);

    localparam int BIT_CNT_W = $clog2(`SPI_DATA_WIDTH) + 1;

    spi_state_t state, next_state;

    spi_div_t               div_cnt;
    logic [BIT_CNT_W-1:0]   bit_cnt;
    spi_data_t              tx_shift;
    spi_data_t              rx_shift;

    logic sclk_int;
    logic sclk_dly;
    logic rise_tick;
    logic fall_tick;
    logic sample_tick;
    logic setup_tick;
    logic bits_done;
    logic clk_stop;
    logic xfer_end;

    // ------------------------------
    // Transfer FSM
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:     if (launch) next_state = START;
            START:    next_state = TRANSFER;
            TRANSFER: if (xfer_end) next_state = STOP;
            STOP:     next_state = IDLE;
            default:  next_state = IDLE;
        endcase
    end

    // ------------------------------
    // SCLK divider and edge detect
    // ------------------------------

    // All sample edges seen and the clock is back at its rest level
    assign bits_done = (bit_cnt == BIT_CNT_W'(`SPI_DATA_WIDTH));
    assign clk_stop  = bits_done && (sclk_int == ctrl.cpol);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt  <= '0;
            bit_cnt  <= '0;
            sclk_int <= 1'b0;
            sclk_dly <= 1'b0;
        end else begin
            if (state == TRANSFER) begin
                if (!clk_stop) begin
                    if (div_cnt >= ctrl.clk_div) begin
                        div_cnt  <= '0;
                        sclk_int <= ~sclk_int;
                        // This toggle lands on a sample edge
                        if (sclk_int != ctrl.sample_on_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
            end else begin
                div_cnt  <= '0;
                sclk_int <= ctrl.cpol;
                if (state == START) begin
                    bit_cnt <= '0;
                end
            end
            sclk_dly <= sclk_int;
        end
    end

    assign rise_tick = sclk_int & ~sclk_dly;
    assign fall_tick = ~sclk_int & sclk_dly;

    assign sample_tick = ctrl.sample_on_rise ? rise_tick : fall_tick;
    assign setup_tick  = ctrl.sample_on_rise ? fall_tick : rise_tick;

    // Last tick already consumed once both clock copies rest at cpol
    assign xfer_end = clk_stop && (sclk_dly == ctrl.cpol);

    // ------------------------------
    // Shifters
    // ------------------------------
    always_ff @(posedge clk) begin
        if (state == START) begin
            tx_shift <= ctrl.tx_data;
        end else if (state == TRANSFER && setup_tick && bit_cnt != '0) begin
            // No shift before the first sample, so CPHA=1 keeps the MSB out
            tx_shift <= {tx_shift[`SPI_DATA_WIDTH-2:0], 1'b0};
        end

        if (state == TRANSFER && sample_tick) begin
            rx_shift <= {rx_shift[`SPI_DATA_WIDTH-2:0], miso};
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign sclk = sclk_int;
    assign mosi = tx_shift[`SPI_DATA_WIDTH-1];
    assign cs_n = (state == START || state == TRANSFER) ? ~ctrl.cs_mask : '1;

    assign engine_busy = (state != IDLE);

    assign res.rx_data = rx_shift;
    assign res.done    = (state == STOP);

    // ------------------------------
    // Checks
    // ------------------------------
    a_cs_onehot : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(~cs_n)
    ) else $error("more than one chip select active");

    // Launch cycle excluded, cpol was just relatched
    a_sclk_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == IDLE && !launch) |-> (sclk == ctrl.cpol)
    ) else $error("sclk not at cpol while idle");

endmodule

//--- source/spi_result_capture.sv
`timescale 1ns/10ps
`include "spi_consts.svh"

module spi_result_capture
    import spi_master_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  spi_result_t res,
    input  logic        cmd_error,
    output spi_data_t   rx_data,
    output logic        transfer_done,
    output logic        error,
    output spi_data_t   xfer_count
);

    // ------------------------------
    // Status pulses and counter
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            transfer_done <= 1'b0;
            error         <= 1'b0;
            xfer_count    <= '0;
        end else begin
            transfer_done <= res.done;
            error         <= cmd_error;
            // Rejected commands never reach the engine, so only done counts
            if (res.done) begin
                xfer_count <= xfer_count + 1'b1;
            end
        end
    end

    // ------------------------------
    // Received byte
    // ------------------------------

    // Holds until the next completed transfer
    always_ff @(posedge clk) begin
        if (res.done) begin
            rx_data <= res.rx_data;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // Decoder only flags errors while idle, engine only finishes while busy
    a_done_xor_error : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(transfer_done && error)
    ) else $error("transfer_done and error in the same cycle");

endmodule

//--- source/spi_master_top.sv
`timescale 1ns/10ps

module spi_master_top
    import spi_master_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // Host side
    input  logic      start,
    input  spi_cmd_t  cmd,
    output logic      busy,
    output spi_data_t rx_data,
    output logic      transfer_done,
    output logic      error,
    output spi_data_t xfer_count,

    // SPI bus
    output logic      sclk,
    output logic      mosi,
    input  logic      miso,
    output spi_cs_t   cs_n
);

    logic        launch;
    logic        cmd_error;
    logic        engine_busy;
    spi_ctrl_t   ctrl;
    spi_result_t res;

    // ------------------------------
    // Command decode
    // ------------------------------
    spi_cmd_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .cmd         (cmd),
        .engine_busy (engine_busy),
        .launch      (launch),
        .cmd_error   (cmd_error),
        .busy        (busy),
        .ctrl        (ctrl)
    );

    // ------------------------------
    // Shift engine
    // ------------------------------
    spi_shift_engine u_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .launch      (launch),
        .ctrl        (ctrl),
        .miso        (miso),
        .sclk        (sclk),
        .mosi        (mosi),
        .cs_n        (cs_n),
        .engine_busy (engine_busy),
        .res         (res)
    );

    // Result registers
    spi_result_capture u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .res           (res),
        .cmd_error     (cmd_error),
        .rx_data       (rx_data),
        .transfer_done (transfer_done),
        .error         (error),
        .xfer_count    (xfer_count)
    );

endmodule

//--- tb/spi_tb_clock.sv
`timescale 1ns/10ps

module spi_tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release reset on a rising edge
    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- tb/spi_slave_model.sv
`timescale 1ns/10ps

module spi_slave_model
    import spi_master_pkg::*;
(
    input  logic      clk,
    input  logic      sclk,
    input  spi_cs_t   cs_n,
    input  logic      mosi,
    input  logic      cpol,
    input  logic      cpha,
    input  spi_data_t resp,
    output logic      miso,
    output spi_data_t mosi_byte,
    output int        edges,
    output int        phase_min,
    output int        phase_max
);

    localparam int DW = $bits(spi_data_t);

    logic      prev_sel    = 1'b0;
    logic      prev_sclk   = 1'b0;
    logic      miso_q      = 1'b0;
    spi_data_t byte_q      = '0;
    int        edges_q     = 0;
    int        samples     = 0;
    int        since       = 0;
    int        phase_min_q = 0;
    int        phase_max_q = 0;
    logic      sel;
    logic      sample_edge;

    assign sel = (cs_n != '1);

    // SCLK only moves on clk edges, so look at the bus half a clock later
    always @(negedge clk) begin
        if (sel && !prev_sel) begin
            // New transfer, MSB goes out right away
            edges_q     = 0;
            samples     = 0;
            since       = 0;
            phase_min_q = 32'h7fff_ffff;
            phase_max_q = 0;
            byte_q      = '0;
            miso_q      = resp[DW-1];
        end else if (sel) begin
            since++;
            if (sclk != prev_sclk) begin
                edges_q++;
                if (edges_q > 1) begin
                    if (since < phase_min_q) phase_min_q = since;
                    if (since > phase_max_q) phase_max_q = since;
                end
                since = 0;
                // Leading edge leaves cpol; CPHA 0 samples there, CPHA 1 on the trailing one
                sample_edge = ((sclk != cpol) == !cpha);
                if (sample_edge) begin
                    byte_q = {byte_q[DW-2:0], mosi};
                    samples++;
                end else if (samples > 0 && samples < DW) begin
                    miso_q = resp[DW-1-samples];
                end
            end
        end
        prev_sel  = sel;
        prev_sclk = sclk;
    end

    assign miso      = miso_q;
    assign mosi_byte = byte_q;
    assign edges     = edges_q;
    assign phase_min = phase_min_q;
    assign phase_max = phase_max_q;

endmodule

//--- tb/spi_master_tb.sv
`timescale 1ns/10ps

module spi_master_tb
    import spi_master_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;

    // One stimulus row with its expected outcome
    typedef struct packed {
        spi_data_t tx;
        spi_sel_t  sel;
        logic      cpol;
        logic      cpha;
        spi_div_t  div;
        spi_data_t resp;
        logic      exp_err;
    } row_t;

    logic      clk;
    logic      rst_n;
    logic      start;
    spi_cmd_t  cmd;
    logic      busy;
    spi_data_t rx_data;
    logic      transfer_done;
    logic      error;
    spi_data_t xfer_count;
    logic      sclk;
    logic      mosi;
    logic      miso;
    spi_cs_t   cs_n;

    logic      slv_cpol;
    logic      slv_cpha;
    spi_data_t slv_resp;
    spi_data_t slv_mosi_byte;
    int        slv_edges;
    int        slv_phase_min;
    int        slv_phase_max;

    row_t      rows[$];
    string     names[$];
    integer    seed;
    int        errors;
    int        valid_rows;
    logic      last_cpol;

    spi_tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    spi_master_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .cmd           (cmd),
        .busy          (busy),
        .rx_data       (rx_data),
        .transfer_done (transfer_done),
        .error         (error),
        .xfer_count    (xfer_count),
        .sclk          (sclk),
        .mosi          (mosi),
        .miso          (miso),
        .cs_n          (cs_n)
    );

    spi_slave_model u_slave (
        .clk       (clk),
        .sclk      (sclk),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .cpol      (slv_cpol),
        .cpha      (slv_cpha),
        .resp      (slv_resp),
        .miso      (miso),
        .mosi_byte (slv_mosi_byte),
        .edges     (slv_edges),
        .phase_min (slv_phase_min),
        .phase_max (slv_phase_max)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("** Error: %s expected %0h actual %0h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        $display("Test failures found");
        $fatal(1, "timeout");
    endtask

    task automatic add_row(input string name, input row_t r);
        names.push_back(name);
        rows.push_back(r);
    endtask

    // Only the row's own slave may be selected, never one for a bad index
    task automatic check_cs(input string name, input row_t r);
        spi_cs_t sel_cs;
        sel_cs = '1;
        if (!r.exp_err) begin
            sel_cs[r.sel] = 1'b0;
        end
        if (cs_n !== '1) begin
            compare_value({name, " cs_n"}, sel_cs, cs_n);
        end
    endtask

    task automatic wait_result(input string name, input row_t r);
        int cycles;
        cycles = 0;
        while (!(transfer_done || error)) begin
            @(negedge clk);
            check_cs(name, r);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) report_timeout({name, ": no transfer_done or error"});
        end
    endtask

    task automatic wait_idle(input string name);
        int cycles;
        cycles = 0;
        while (busy) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) report_timeout({name, ": busy never went low"});
        end
    endtask

    task automatic run_row(input string name, input row_t r);
        int cycles;
        @(posedge clk);
        cmd.tx_data   <= r.tx;
        cmd.slave_sel <= r.sel;
        cmd.cpol      <= r.cpol;
        cmd.cpha      <= r.cpha;
        cmd.clk_div   <= r.div;
        slv_cpol      <= r.cpol;
        slv_cpha      <= r.cpha;
        slv_resp      <= r.resp;
        start         <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (!r.exp_err) begin
            // Second start in mid transfer, with a different command
            cycles = 0;
            while (cs_n === '1) begin
                @(negedge clk);
                cycles++;
                if (cycles > TIMEOUT_CYCLES) report_timeout({name, ": cs_n never went low"});
            end
            @(posedge clk);
            cmd.tx_data   <= ~r.tx;
            cmd.slave_sel <= r.sel + 1'b1;
            start         <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        wait_result(name, r);
        compare_value({name, " error"}, r.exp_err, error);
        compare_value({name, " done"}, !r.exp_err, transfer_done);
        if (r.exp_err) begin
            compare_value({name, " count"}, spi_data_t'(valid_rows), xfer_count);
        end else begin
            valid_rows++;
            last_cpol = r.cpol;
            compare_value({name, " rx_data"}, r.resp, rx_data);
            compare_value({name, " mosi byte"}, r.tx, slv_mosi_byte);
            compare_value({name, " sclk edges"}, 16, slv_edges);
            compare_value({name, " phase min"}, r.div + 1, slv_phase_min);
            compare_value({name, " phase max"}, r.div + 1, slv_phase_max);
            compare_value({name, " count"}, spi_data_t'(valid_rows), xfer_count);
        end
        wait_idle(name);
        compare_value({name, " cs_n idle"}, spi_cs_t'('1), cs_n);
        compare_value({name, " sclk idle"}, last_cpol, sclk);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        logic [31:0] rnd;
        int          cycles;
        seed       = 32'hdf5f_2b92;
        errors     = 0;
        valid_rows = 0;
        last_cpol  = 1'b0;
        start      <= 1'b0;
        cmd        <= '0;
        slv_cpol   <= 1'b0;
        slv_cpha   <= 1'b0;
        slv_resp   <= '0;

        // tx, slave, cpol, cpha, clk_div, response, expect error
        add_row("mode0_s0_div0", row_t'{8'ha5, 2'd0, 1'b0, 1'b0, 16'd0, 8'h3c, 1'b0});
        add_row("mode1_s1_div1", row_t'{8'h5a, 2'd1, 1'b0, 1'b1, 16'd1, 8'hc3, 1'b0});
        add_row("mode2_s2_div5", row_t'{8'hf0, 2'd2, 1'b1, 1'b0, 16'd5, 8'h0f, 1'b0});
        add_row("bad_index", row_t'{8'h12, 2'd3, 1'b0, 1'b0, 16'd0, 8'h00, 1'b1});
        add_row("mode3_s0_div1", row_t'{8'h81, 2'd0, 1'b1, 1'b1, 16'd1, 8'h7e, 1'b0});
        add_row("mode3_s2_div0", row_t'{8'h96, 2'd2, 1'b1, 1'b1, 16'd0, 8'h69, 1'b0});
        add_row("mode2_s1_div0", row_t'{8'h01, 2'd1, 1'b1, 1'b0, 16'd0, 8'h80, 1'b0});
        for (int i = 0; i < 6; i++) begin
            rnd = $random(seed);
            add_row($sformatf("random_%0d", i), row_t'{rnd[7:0], spi_sel_t'(rnd[9:8] % 3),
                    rnd[10], rnd[11], spi_div_t'(rnd[13:12]), rnd[23:16], 1'b0});
        end

        cycles = 0;
        while (!rst_n) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) report_timeout("reset never released");
        end
        compare_value("reset cs_n", spi_cs_t'('1), cs_n);
        compare_value("reset sclk", 0, sclk);
        compare_value("reset busy", 0, busy);
        compare_value("reset status", 0, {transfer_done, error});
        compare_value("reset count", 0, xfer_count);

        foreach (rows[i]) begin
            run_row(names[i], rows[i]);
        end
        compare_value("final count", valid_rows, xfer_count);

        if (errors == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "checks failed");
        end
    end

endmodule

//--- spi_master.f
+incdir+source
source/spi_master_pkg.sv
source/spi_cmd_decode.sv
source/spi_shift_engine.sv
source/spi_result_capture.sv
source/spi_master_top.sv
tb/spi_tb_clock.sv
tb/spi_slave_model.sv
tb/spi_master_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the SPI master testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f spi_master.f \
    --top-module spi_master_tb -o spi_master_sim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/spi_master_sim 2>&1)
echo "$out"
echo "$out" | grep -q "All tests passed!" && echo "PASS" || { echo "FAIL"; exit 1; }
